/* project.f */
+incdir+src
src/classifierPkg.sv
src/reluNeuron.sv
src/scoreBank.sv
src/classSelector.sv
src/neuralClassifier.sv
test/classifier_assertions.sv
test/classifierTb.sv

/* run.sh */
#!/bin/sh
# Builds the classifier testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module classifierTb \
	-f project.f --Mdir obj_dir -o classifierSim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/classifierSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation ended with status $status"
	exit 1
fi

if echo "$output" | grep -q "TEST RESULT: PASS"; then
	exit 0
fi
exit 1

/* test/classifier_patterns.mem */
// one record per line, 16-bit hex columns from left to right:
// gap (idle cycles before the sample), expected class, expected score, feature 9 ... feature 0
0000_0001_0003_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000 // bias only
0000_0002_0006_0000_0000_0002_0000_0000_0000_0000_0000_0000_0000
0000_0000_0000_0000_FFFF_0000_0000_0000_0000_0000_0000_0000_0000 // all four sums negative
0000_0000_0008_0003_0000_0000_FFFF_0000_0000_0000_0000_0000_0000 // tie inside bank A
0001_0002_0002_0000_0000_0000_0002_0000_0000_0000_0000_0000_0000 // tie inside bank B
0000_0000_000B_0000_0000_0003_0000_0000_0000_0000_0000_0000_0000 // tie across the banks
0000_0003_000C_0000_0000_0000_0000_0000_0000_0002_0000_0000_0000
0002_0003_4000_2000_0000_0000_0000_0000_0000_0000_0000_0000_0000 // wrapped product
0000_0003_7000_0000_0000_1000_0000_3000_0000_0000_0000_0000_0000 // wrapped sum
0000_0001_0009_0000_0000_0000_0000_0000_0000_0000_0003_0002_0001
0000_0003_0004_0001_0000_0000_0000_0000_FFFF_0000_0000_0000_0000
0003_0001_0004_0000_0000_0000_0000_0000_0001_0000_0000_0000_0001
0000_0002_0004_0000_0000_0001_0001_0000_0000_0000_0000_0000_0000
0000_0000_7FF6_0000_0000_0000_0000_0000_0000_0000_0000_0000_8000 // bias wraps positive
0001_0001_0012_0000_0000_0000_0000_0006_0000_FFFF_0000_0000_0000 // tie of classes 1 and 3
0000_0002_0008_0000_0000_0000_0000_0000_0000_0000_FFFE_0000_0000
0000_0000_0000_0000_FFFF_0000_0000_0000_0000_0000_0000_0000_0000
0000_0001_0003_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000

/* test/classifierTb.sv */
`timescale 1ns/1ps
`include "classifier_config.svh"

module classifierTb;
	import classifierPkg::*;

	localparam int patternCount = 18;
	localparam int latency = 5;
	localparam int clockPeriod = 100;
	localparam int resetCycles = 5;
	localparam int driveDelay = 1;
	localparam int timeoutCycles = patternCount * 4 + 50;

	// record layout, from the low bits up.
	localparam int recordBits = 13 * `DATA_WIDTH;
	localparam int scoreLsb = `NUM_FEATURES * `DATA_WIDTH;
	localparam int classLsb = scoreLsb + `DATA_WIDTH;
	localparam int gapLsb = classLsb + `DATA_WIDTH;

	logic clk;
	logic reset;
	logic sampleValid;
	featureVector_t features;
	logic predValid;
	classResult_t prediction;

	logic [recordBits-1:0] patterns [patternCount];
	classResult_t expectedQueue [$];
	int indexQueue [$];
	int edgeQueue [$];	// edge count at which each sample was driven.
	int seed = 76;
	int cycleCount = 0;
	int edgesSinceReset = 0;
	int resultCount = 0;

	neuralClassifier DUT (
		.clk(clk),
		.reset(reset),
		.sampleValid(sampleValid),
		.features(features),
		.predValid(predValid),
		.prediction(prediction)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clockPeriod / 2) clk = ~clk;
	end

	task automatic stopOnFailure();
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic checkValue(input string testName, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %s expected %0h actual %0h", testName, expected, actual);
			stopOnFailure();
		end
	endtask

	// idle cycles carry random features that must not reach the output.
	task automatic driveIdle();
		featureVector_t noise;
		for (int i = 0; i < `NUM_FEATURES; i++)
		begin
			noise.feature[i] = activation_t'($random(seed));
		end
		features = noise;
		sampleValid = 1'b0;
	endtask

	task automatic driveSample(input int index);
		logic [recordBits-1:0] record;
		classResult_t expected;
		record = patterns[index];
		expected.classIndex = classIndex_t'(record[classLsb +: `DATA_WIDTH]);
		expected.score = activation_t'(record[scoreLsb +: `DATA_WIDTH]);
		features = featureVector_t'(record[scoreLsb-1:0]);
		sampleValid = 1'b1;
		expectedQueue.push_back(expected);
		indexQueue.push_back(index);
		edgeQueue.push_back(cycleCount);
	endtask

	always @(posedge clk)
	begin
		cycleCount = cycleCount + 1;
		if (reset)
			edgesSinceReset = 0;
		else
			edgesSinceReset = edgesSinceReset + 1;
	end

	// outputs are compared at the falling edge, half a period after they change.
	always @(negedge clk)
	begin
		classResult_t expected;
		int index;
		int driveEdge;
		if (cycleCount > 0 && edgesSinceReset <= 1)
		begin
			checkValue("predValid after reset", 0, 32'(predValid));
			checkValue("prediction after reset", 0, 32'(prediction));
		end
		if (predValid)
		begin
			if (expectedQueue.size() == 0)
			begin
				$display("predValid was high at cycle %0d with no sample in flight", cycleCount);
				stopOnFailure();
			end
			else
			begin
				expected = expectedQueue.pop_front();
				index = indexQueue.pop_front();
				driveEdge = edgeQueue.pop_front();
				checkValue($sformatf("pattern %0d latency", index), latency,
					32'(cycleCount - driveEdge));
				checkValue($sformatf("pattern %0d class", index), 32'(expected.classIndex),
					32'(prediction.classIndex));
				checkValue($sformatf("pattern %0d score", index), 32'(expected.score),
					32'(prediction.score));
				resultCount = resultCount + 1;
			end
		end
	end

	initial
	begin
		int gap;
		reset = 1'b1;
		sampleValid = 1'b0;
		features = '0;
		$readmemh("test/classifier_patterns.mem", patterns);
		if ($isunknown(patterns[patternCount-1]) || patterns[patternCount-1] == '0)
		begin
			$display("the pattern file could not be read or holds fewer than %0d records",
				patternCount);
			stopOnFailure();
		end
		repeat (resetCycles) @(posedge clk);
		#(driveDelay);
		reset = 1'b0;
		for (int p = 0; p < patternCount; p++)
		begin
			gap = int'(patterns[p][gapLsb +: `DATA_WIDTH]);
			repeat (gap)
			begin
				@(posedge clk);
				#(driveDelay);
				driveIdle();
			end
			@(posedge clk);
			#(driveDelay);
			driveSample(p);
		end
		while (resultCount < patternCount)
		begin
			@(posedge clk);
			#(driveDelay);
			driveIdle();
		end
		// a few more idle cycles show that no stray result follows.
		repeat (latency + 2)
		begin
			@(posedge clk);
			#(driveDelay);
			driveIdle();
		end
		$display("TEST RESULT: PASS");
		$finish;
	end

	initial
	begin
		#(timeoutCycles * clockPeriod);
		$display("the run timed out after %0d clock cycles", timeoutCycles);
		stopOnFailure();
	end

endmodule

/* test/classifier_assertions.sv */
`timescale 1ns/1ps
`include "classifier_config.svh"

module classifierAssertions (
	input logic clk,
	input logic reset,
	input logic sampleValid,
	input logic predValid,
	input classifierPkg::classResult_t prediction
);
	import classifierPkg::*;

	localparam int latency = 5;
	localparam int indexBits = `CLASS_INDEX_WIDTH + 1;

	// the strobe leaves the pipeline five edges after it entered.
	validLatency: assert property (
		@(posedge clk) disable iff (reset)
		predValid == $past(sampleValid, latency)
	)
	else $error("predValid differs from sampleValid %0d cycles earlier", latency);

	resetClearsValid: assert property (@(posedge clk) reset |=> !predValid)
	else $error("predValid is high in the cycle after reset");

	validKnown: assert property (@(posedge clk) disable iff (reset) !$isunknown(predValid))
	else $error("predValid is unknown");

	// a ReLU output can never carry a set sign bit.
	scoreNotNegative: assert property (
		@(posedge clk) disable iff (reset)
		!prediction.score[`DATA_WIDTH-1]
	)
	else $error("prediction score %0h is negative", prediction.score);

	classInRange: assert property (
		@(posedge clk) disable iff (reset)
		{1'b0, prediction.classIndex} < indexBits'(`NUM_CLASSES)
	)
	else $error("class index %0d is out of range", prediction.classIndex);

endmodule

bind neuralClassifier classifierAssertions assertionChecks (
	.clk(clk),
	.reset(reset),
	.sampleValid(sampleValid),
	.predValid(predValid),
	.prediction(prediction)
);

/* src/neuralClassifier.sv */
`timescale 1ns/1ps
`include "classifier_config.svh"

module neuralClassifier (
	input logic clk,
	input logic reset,
	input logic sampleValid,
	input classifierPkg::featureVector_t features,
	output logic predValid,
	output classifierPkg::classResult_t prediction
);
	import classifierPkg::*;

	bankWinner_t winnerA;
	bankWinner_t winnerB;

	// classes 0 and 1.
	scoreBank #(
		.bankWeights(`BANK_A_WEIGHTS)
	) bankA (
		.clk(clk),
		.reset(reset),
		.features(features),
		.winner(winnerA)
	);

	// classes 2 and 3.
	scoreBank #(
		.bankWeights(`BANK_B_WEIGHTS)
	) bankB (
		.clk(clk),
		.reset(reset),
		.features(features),
		.winner(winnerB)
	);

	// the strobe bypasses the banks and is delayed inside the selector.
	classSelector selector (
		.clk(clk),
		.reset(reset),
		.sampleValid(sampleValid),
		.winnerA(winnerA),
		.winnerB(winnerB),
		.predValid(predValid),
		.prediction(prediction)
	);

endmodule

/* src/classSelector.sv */
`timescale 1ns/1ps
`include "classifier_config.svh"

module classSelector (
	input logic clk,
	input logic reset,
	input logic sampleValid,
	input classifierPkg::bankWinner_t winnerA,
	input classifierPkg::bankWinner_t winnerB,
	output logic predValid,
	output classifierPkg::classResult_t prediction
);
	import classifierPkg::*;

	// one stage each for the three neuron registers and the bank register.
	localparam int validDepth = 4;

	logic [validDepth-1:0] validShift;
	classResult_t result;

	// bank B holds the upper classes, so its local index is offset by the bank size.
	// It wins only with a strictly greater score.
	always_comb
	begin
		if (winnerB.score > winnerA.score)
		begin
			result.classIndex = classIndex_t'(winnerB.localIndex) + classIndex_t'(`BANK_SIZE);
			result.score = winnerB.score;
		end
		else
		begin
			result.classIndex = classIndex_t'(winnerA.localIndex);
			result.score = winnerA.score;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			prediction <= '0;
		end
		else
		begin
			prediction <= result;
		end
	end

	// the strobe follows its sample through the upstream pipeline.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			validShift <= '0;
			predValid <= 1'b0;
		end
		else
		begin
			validShift <= {validShift[validDepth-2:0], sampleValid};
			predValid <= validShift[validDepth-1];	// lines up with the registered result.
		end
	end

endmodule

/* src/scoreBank.sv */
`timescale 1ns/1ps
`include "classifier_config.svh"

module scoreBank #(
	parameter classifierPkg::neuronWeights_t [`BANK_SIZE-1:0] bankWeights = '0
) (
	input logic clk,
	input logic reset,
	input classifierPkg::featureVector_t features,
	output classifierPkg::bankWinner_t winner
);
	import classifierPkg::*;

	// width of the local index field, taken from the winner struct itself.
	localparam int indexBits = $bits(bankWinner_t) - $bits(activation_t);

	activation_t [`BANK_SIZE-1:0] score;
	bankWinner_t best;

	// all neurons of the bank see the same features.
	genvar n;
	generate
		for (n = 0; n < `BANK_SIZE; n++)
		begin : neuron
			reluNeuron #(
				.weights(bankWeights[n])
			) unit (
				.clk(clk),
				.reset(reset),
				.features(features),
				.activation(score[n])
			);
		end
	endgenerate

	// scan in index order.
	// Only a strictly greater score takes over, so a tie keeps the lower index.
	always_comb
	begin
		best.score = score[0];
		best.localIndex = '0;
		for (int i = 1; i < `BANK_SIZE; i++)
		begin
			if (score[i] > best.score)
			begin
				best.score = score[i];
				best.localIndex = indexBits'(i);
			end
		end
	end

	// the bank result is registered one cycle after the neuron outputs.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			winner <= '0;
		end
		else
		begin
			winner <= best;
		end
	end

endmodule

/* src/reluNeuron.sv */
`timescale 1ns/1ps
`include "classifier_config.svh"

module reluNeuron #(
	parameter classifierPkg::neuronWeights_t weights = '0
) (
	input logic clk,
	input logic reset,
	input classifierPkg::featureVector_t features,
	output classifierPkg::activation_t activation
);
	import classifierPkg::*;

	featureVector_t featureReg;	// stage 1 holds the sample.
	activation_t [`NUM_FEATURES-1:0] product;
	activation_t sumNext;
	activation_t sumReg;	// stage 2 holds the wrapped sum.

	// stage 1 captures the features on every cycle.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			featureReg <= '0;
		end
		else
		begin
			featureReg <= features;
		end
	end

	// every product keeps only its low 16 bits, and the sum wraps the same way.
	always_comb
	begin
		sumNext = weights.bias;
		for (int i = 0; i < `NUM_FEATURES; i++)
		begin
			product[i] = activation_t'(featureReg.feature[i] * weights.weight[i]);
			sumNext = sumNext + product[i];
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sumReg <= '0;
		end
		else
		begin
			sumReg <= sumNext;
		end
	end

	// stage 3 applies the ReLU.
	// A set sign bit means the sum is negative and the output becomes zero.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			activation <= '0;
		end
		else if (sumReg[`DATA_WIDTH-1])
		begin
			activation <= '0;
		end
		else
		begin
			activation <= sumReg;
		end
	end

endmodule

/* src/classifierPkg.sv */
`include "classifier_config.svh"

package classifierPkg;

	// features, weights, biases and scores share one signed fixed-point format.
	typedef logic signed [`DATA_WIDTH-1:0] activation_t;

	// global class number.
	typedef logic [`CLASS_INDEX_WIDTH-1:0] classIndex_t;

	// one sample. Feature 0 lives in the low bits.
	typedef struct packed
	{
		activation_t [`NUM_FEATURES-1:0] feature;
	} featureVector_t;

	// the constants of a single neuron.
	typedef struct packed
	{
		activation_t [`NUM_FEATURES-1:0] weight;
		activation_t bias;
	} neuronWeights_t;

	typedef struct packed
	{
		activation_t score;
		logic localIndex;	// position of the winning neuron inside its bank.
	} bankWinner_t;

	typedef struct packed
	{
		classIndex_t classIndex;
		activation_t score;
	} classResult_t;

endpackage

/* src/classifier_config.svh */
`ifndef CLASSIFIER_CONFIG_SVH
`define CLASSIFIER_CONFIG_SVH

// widths and sizes of the classifier.
`define DATA_WIDTH 16
`define NUM_FEATURES 10
`define NUM_CLASSES 4
`define BANK_SIZE 2
`define CLASS_INDEX_WIDTH 2

// each neuron entry lists weight 9 down to weight 0 and then the bias.
// This order matches the packed neuron weight struct, which keeps the bias in the low bits.
`define CLASS0_WEIGHTS { \
	16'sd6, \
	-16'sd1, \
	16'sd7, \
	16'sd0, \
	16'sd2, \
	-16'sd4, \
	16'sd1, \
	16'sd5, \
	-16'sd2, \
	16'sd3, \
	-16'sd10 }

`define CLASS1_WEIGHTS { \
	16'sd1, \
	16'sd5, \
	16'sd0, \
	-16'sd2, \
	16'sd2, \
	16'sd6, \
	-16'sd3, \
	16'sd1, \
	16'sd4, \
	-16'sd5, \
	16'sd3 }

`define CLASS2_WEIGHTS { \
	-16'sd2, \
	16'sd0, \
	16'sd5, \
	16'sd3, \
	-16'sd1, \
	16'sd1, \
	16'sd4, \
	-16'sd6, \
	16'sd2, \
	16'sd2, \
	-16'sd4 }

`define CLASS3_WEIGHTS { \
	16'sd2, \
	16'sd3, \
	-16'sd5, \
	16'sd1, \
	16'sd4, \
	-16'sd2, \
	16'sd6, \
	16'sd2, \
	-16'sd3, \
	16'sd1, \
	16'sd0 }

// neuron 0 of a bank sits in the low bits of the bank constant.
`define BANK_A_WEIGHTS {`CLASS1_WEIGHTS, `CLASS0_WEIGHTS}
`define BANK_B_WEIGHTS {`CLASS3_WEIGHTS, `CLASS2_WEIGHTS}

`endif
